/* calib_defines.svh */
// Shared sizing macros for the multi-channel ADC calibration stage
`ifndef CALIB_DEFINES_SVH
`define CALIB_DEFINES_SVH

// Width of one ADC sample and of each offset value
`define CALIB_DATA_WIDTH 16

// Number of interleaved channels on the sample stream
`define CALIB_CHANNELS 4

// Width of the channel tag that travels with each sample
`define CALIB_DEST_WIDTH 2

// Width of a per-channel left shift amount
`define CALIB_SHIFT_WIDTH 4

// Width of a configuration register address
`define CALIB_ADDR_WIDTH 4

`endif

/* calibration.sv */
// Pipeline stage that applies per-channel offset and optional left shift to each sample
`timescale 1ns/10ps
`include "calib_defines.svh"

module calibration (
    input  logic clock,
    input  logic reset,
    input  config_pkg::calibration_config_t calib_config,
    input  logic in_valid,
    output logic in_ready,
    input  stream_pkg::raw_sample_t in_sample,
    output logic out_valid,
    input  logic out_ready,
    output stream_pkg::calibrated_sample_t out_sample
);

    config_pkg::channel_config_t channel;
    logic signed [`CALIB_DATA_WIDTH-1:0] offset_sum;
    logic signed [`CALIB_DATA_WIDTH-1:0] shifted_sum;
    logic signed [`CALIB_DATA_WIDTH-1:0] corrected;
    logic offset_saturated;
    logic accept;

    // Settings of the channel named by the incoming tag
    assign channel = calib_config.channels[in_sample.dest];

    // Offset correction with limits chosen by the channel's signedness
    saturating_adder offset_adder (
        .a(in_sample.data),
        .b(channel.offset),
        .output_signed(channel.output_signed),
        .sum(offset_sum),
        .saturated(offset_saturated)
    );

    // Gain correction by a power of two
    // Bits shifted past the top are dropped, only the low data-width bits remain
    assign shifted_sum = offset_sum <<< channel.shift;

    assign corrected = calib_config.shift_enable ? shifted_sum : offset_sum;

    // The output register can load when empty or when it drains this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Result, tag and clamp flag are captured together
    always_ff @(posedge clock) begin
        if (accept) begin
            out_sample.data <= corrected;
            out_sample.dest <= in_sample.dest;
            out_sample.saturated <= offset_saturated;
        end
    end

endmodule

/* calibration_checker.sv */
// Output monitor for the calibration stage that compares each sample with the expected queue
`timescale 1ns/10ps

module calibration_checker (
    input logic clock,
    input logic reset,
    input logic out_valid,
    input logic out_ready,
    input stream_pkg::calibrated_sample_t out_sample
);

    // Expected samples in transfer order, filled by the testbench model
    stream_pkg::calibrated_sample_t expected_queue[$];
    int match_count = 0;
    int error_count = 0;

    // Called by the testbench for every sample the DUT accepts
    task automatic add_expected(input stream_pkg::calibrated_sample_t sample);
        expected_queue.push_back(sample);
    endtask

    function automatic int pending_count();
        return expected_queue.size();
    endfunction

    // A transfer happens on the edge where valid and ready are both high
    // Values read here are the ones present just before that edge
    always @(posedge clock) begin : compare_output
        stream_pkg::calibrated_sample_t expected;
        if (reset && out_valid && out_ready) begin
            if (expected_queue.size() == 0) begin
                $display("Error: the DUT sent a sample at %0t that matches no accepted input",
                         $time);
                error_count++;
            end else begin
                expected = expected_queue.pop_front();
                // Data, channel tag and clamp flag must all agree
                if (out_sample !== expected) begin
                    $display("FAIL %0t: dest/data/sat got %0d/%0d/%0b, expected %0d/%0d/%0b",
                             $time, out_sample.dest, out_sample.data, out_sample.saturated,
                             expected.dest, expected.data, expected.saturated);
                    error_count++;
                end else begin
                    match_count++;
                end
            end
        end
    end

endmodule

/* calibration_registers.sv */
// Register bank holding the calibration settings, written through a strobe port
`timescale 1ns/10ps
`include "calib_defines.svh"

module calibration_registers (
    input  logic clock,
    input  logic reset,
    input  logic reg_write,
    input  logic [`CALIB_ADDR_WIDTH-1:0] reg_address,
    input  logic [`CALIB_DATA_WIDTH-1:0] reg_data,
    output config_pkg::calibration_config_t calib_config
);

    logic [`CALIB_CHANNELS-1:0] offset_hit;
    logic [`CALIB_CHANNELS-1:0] shift_hit;
    logic control_hit;

    // Address decode against the map in config_pkg
    // Addresses outside the map match nothing and the write is dropped
    always_comb begin
        for (int ch = 0; ch < `CALIB_CHANNELS; ch++) begin
            offset_hit[ch] = (int'(reg_address) == config_pkg::OFFSET_BASE + ch);
            shift_hit[ch] = (int'(reg_address) == config_pkg::SHIFT_BASE + ch);
        end
        control_hit = (int'(reg_address) == config_pkg::CONTROL_ADDRESS);
    end

    // Reset leaves zero offsets, no shift and all channels unsigned
    always_ff @(posedge clock) begin
        if (!reset) begin
            calib_config <= '0;
        end else if (reg_write) begin
            for (int ch = 0; ch < `CALIB_CHANNELS; ch++) begin
                if (offset_hit[ch]) begin
                    calib_config.channels[ch].offset <= reg_data;
                end
                if (shift_hit[ch]) begin
                    calib_config.channels[ch].shift <= reg_data[`CALIB_SHIFT_WIDTH-1:0];
                end
                // Signedness bits sit above the enable bit in the control word
                if (control_hit) begin
                    calib_config.channels[ch].output_signed <=
                        reg_data[config_pkg::OUTPUT_SIGNED_LSB + ch];
                end
            end
            if (control_hit) begin
                calib_config.shift_enable <= reg_data[config_pkg::SHIFT_ENABLE_BIT];
            end
        end
    end

endmodule

/* calibration_top.sv */
// Top level of the calibration stage with configuration bank and stream slices
`timescale 1ns/10ps
`include "calib_defines.svh"

module calibration_top (
    input  logic clock,
    input  logic reset,
    input  logic reg_write,
    input  logic [`CALIB_ADDR_WIDTH-1:0] reg_address,
    input  logic [`CALIB_DATA_WIDTH-1:0] reg_data,
    input  logic in_valid,
    output logic in_ready,
    input  stream_pkg::raw_sample_t in_sample,
    output logic out_valid,
    input  logic out_ready,
    output stream_pkg::calibrated_sample_t out_sample
);

    config_pkg::calibration_config_t calib_config;

    // Stream between the input slice and the calibration stage
    logic raw_valid;
    logic raw_ready;
    stream_pkg::raw_sample_t raw_sample;

    // Stream between the calibration stage and the output slice
    logic cal_valid;
    logic cal_ready;
    stream_pkg::calibrated_sample_t cal_sample;

    calibration_registers registers (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .calib_config(calib_config)
    );

    // Input slice decouples the upstream ready from the calibration stage
    stream_slice #(
        .payload_t(stream_pkg::raw_sample_t)
    ) input_slice (
        .clock(clock),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_payload(in_sample),
        .out_valid(raw_valid),
        .out_ready(raw_ready),
        .out_payload(raw_sample)
    );

    calibration calibration_stage (
        .clock(clock),
        .reset(reset),
        .calib_config(calib_config),
        .in_valid(raw_valid),
        .in_ready(raw_ready),
        .in_sample(raw_sample),
        .out_valid(cal_valid),
        .out_ready(cal_ready),
        .out_sample(cal_sample)
    );

    // Output slice absorbs downstream back-pressure
    stream_slice #(
        .payload_t(stream_pkg::calibrated_sample_t)
    ) output_slice (
        .clock(clock),
        .reset(reset),
        .in_valid(cal_valid),
        .in_ready(cal_ready),
        .in_payload(cal_sample),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_payload(out_sample)
    );

endmodule

/* config_pkg.sv */
// Calibration configuration types and the register address map
`include "calib_defines.svh"

package config_pkg;

    // Settings for a single channel
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] offset;
        logic [`CALIB_SHIFT_WIDTH-1:0] shift;
        logic output_signed;
    } channel_config_t;

    // Complete configuration seen by the calibration stage
    // Channel c lives at index c of the packed array
    typedef struct packed {
        logic shift_enable;
        channel_config_t [`CALIB_CHANNELS-1:0] channels;
    } calibration_config_t;

    // Offsets occupy one address per channel starting here
    localparam int OFFSET_BASE = 0;

    // Shift amounts occupy one address per channel starting here
    localparam int SHIFT_BASE = 4;

    // Control word with the global enable and the signedness bits
    localparam int CONTROL_ADDRESS = 8;
    localparam int SHIFT_ENABLE_BIT = 0;
    localparam int OUTPUT_SIGNED_LSB = 1;

endpackage

/* flist.f */
+incdir+.
stream_pkg.sv
config_pkg.sv
saturating_adder.sv
stream_slice.sv
calibration.sv
calibration_registers.sv
calibration_top.sv
calibration_checker.sv
tb_calibration.sv

/* saturating_adder.sv */
// Signed adder that clamps its result to signed or unsigned output limits
`timescale 1ns/10ps
`include "calib_defines.svh"

module saturating_adder (
    input  logic signed [`CALIB_DATA_WIDTH-1:0] a,
    input  logic signed [`CALIB_DATA_WIDTH-1:0] b,
    input  logic output_signed,
    output logic signed [`CALIB_DATA_WIDTH-1:0] sum,
    output logic saturated
);

    localparam int W = `CALIB_DATA_WIDTH;

    // Limits expressed in the widened domain so they compare directly with the raw sum
    localparam logic signed [W:0] MAX_VALUE = {2'b00, {(W-1){1'b1}}};
    localparam logic signed [W:0] MIN_SIGNED = {2'b11, {(W-1){1'b0}}};

    logic signed [W:0] wide_sum;
    logic signed [W:0] low_limit;

    // One guard bit is enough to hold any sum of two W-bit operands
    assign wide_sum = {a[W-1], a} + {b[W-1], b};

    // Unsigned channels may not go below zero
    assign low_limit = output_signed ? MIN_SIGNED : '0;

    always_comb begin
        sum = wide_sum[W-1:0];
        saturated = 1'b0;
        if (wide_sum > MAX_VALUE) begin
            sum = MAX_VALUE[W-1:0];
            saturated = 1'b1;
        end else if (wide_sum < low_limit) begin
            sum = low_limit[W-1:0];
            saturated = 1'b1;
        end
    end

endmodule

/* stream_pkg.sv */
// Sample stream payload types before and after calibration
`include "calib_defines.svh"

package stream_pkg;

    // Sample as delivered by the ADC interleaver
    // The channel tag selects which calibration settings apply
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] data;
        logic [`CALIB_DEST_WIDTH-1:0] dest;
    } raw_sample_t;

    // Sample after offset and gain correction
    // The flag is set when the offset adder had to clamp the result
    typedef struct packed {
        logic signed [`CALIB_DATA_WIDTH-1:0] data;
        logic [`CALIB_DEST_WIDTH-1:0] dest;
        logic saturated;
    } calibrated_sample_t;

endpackage

/* stream_slice.sv */
// Two-entry skid buffer that registers a valid/ready stream at full throughput
`timescale 1ns/10ps

module stream_slice #(
    parameter type payload_t = logic
) (
    input  logic clock,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  payload_t in_payload,
    output logic out_valid,
    input  logic out_ready,
    output payload_t out_payload
);

    payload_t main_payload;
    payload_t spare_payload;
    logic main_valid;
    logic spare_valid;
    logic main_free;
    logic spare_load;

    // The main entry can take new data when it is empty or being read out
    assign main_free = !main_valid || out_ready;

    // The spare entry catches the item that arrives while the main entry is stalled
    assign spare_load = !main_free && in_valid && !spare_valid;

    // Ready comes straight from a flop, so out_ready never reaches in_ready
    assign in_ready = !spare_valid;

    assign out_valid = main_valid;
    assign out_payload = main_payload;

    always_ff @(posedge clock) begin
        if (!reset) begin
            main_valid <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            // A waiting spare item goes first to keep the order
            main_valid <= spare_valid || in_valid;
            spare_valid <= 1'b0;
        end else if (spare_load) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (main_free) begin
            main_payload <= spare_valid ? spare_payload : in_payload;
        end
        if (spare_load) begin
            spare_payload <= in_payload;
        end
    end

endmodule

/* tb_calibration.sv */
// Testbench for the calibration stage with random stimulus and a reference model
`timescale 1ns/10ps
`include "calib_defines.svh"

module tb_calibration;

    localparam int W = `CALIB_DATA_WIDTH;
    localparam int MAX_VALUE = (1 << (W - 1)) - 1;
    localparam int MIN_VALUE = -(1 << (W - 1));
    localparam int SAMPLES_PER_TEST = 200;
    localparam int TEST_COUNT = 6;
    // Twenty cycles per sample plus room for resets, register writes and drains
    localparam int WATCHDOG_CYCLES = SAMPLES_PER_TEST * TEST_COUNT * 20 + 2000;

    // Kinds of sample and offset values
    localparam int SMALL = 0;
    localparam int LARGE = 1;
    localparam int FULL = 2;
    localparam int NON_NEGATIVE = 3;

    logic clock;
    logic reset;
    logic reg_write;
    logic [`CALIB_ADDR_WIDTH-1:0] reg_address;
    logic [`CALIB_DATA_WIDTH-1:0] reg_data;
    logic in_valid;
    logic in_ready;
    stream_pkg::raw_sample_t in_sample;
    logic out_valid;
    logic out_ready;
    stream_pkg::calibrated_sample_t out_sample;

    integer seed;
    int tb_errors;

    // Software view of the register bank, kept in step with every write
    int offset_model [`CALIB_CHANNELS];
    int shift_model [`CALIB_CHANNELS];
    bit signed_model [`CALIB_CHANNELS];
    bit shift_enable_model;

    calibration_top uut (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_sample(in_sample),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_sample(out_sample)
    );

    calibration_checker output_checker (
        .clock(clock),
        .reset(reset),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_sample(out_sample)
    );

    always #4 clock = ~clock;

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Random value over the whole signed sample range
    function automatic int random_word();
        int value;
        value = $random(seed) & ((1 << W) - 1);
        return (value > MAX_VALUE) ? value - (1 << W) : value;
    endfunction

    function automatic int random_data(input int kind);
        int magnitude;
        case (kind)
            SMALL: return $random(seed) % 8001;
            // Near full scale so that a same-sign offset overflows
            LARGE: begin
                magnitude = 24000 + ($random(seed) & 8191);
                return ($random(seed) & 1) ? -magnitude : magnitude;
            end
            NON_NEGATIVE: return $random(seed) & MAX_VALUE;
            default: return random_word();
        endcase
    endfunction

    // The expected output clamps the offset sum to the channel limits and then shifts and truncates
    function automatic stream_pkg::calibrated_sample_t expected_sample(input int data,
                                                                       input int dest);
        stream_pkg::calibrated_sample_t result;
        int total;
        int low_limit;
        total = data + offset_model[dest];
        low_limit = signed_model[dest] ? MIN_VALUE : 0;
        result.saturated = 1'b0;
        if (total > MAX_VALUE) begin
            total = MAX_VALUE;
            result.saturated = 1'b1;
        end else if (total < low_limit) begin
            total = low_limit;
            result.saturated = 1'b1;
        end
        if (shift_enable_model) begin
            total = total << shift_model[dest];
        end
        result.data = total[W-1:0];
        result.dest = dest[`CALIB_DEST_WIDTH-1:0];
        return result;
    endfunction

    // One strobed write, effective after the edge it is sampled on
    task automatic write_register(input int address, input int value);
        reg_address = address[`CALIB_ADDR_WIDTH-1:0];
        reg_data = value[W-1:0];
        reg_write = 1'b1;
        @(posedge clock);
        #1;
        reg_write = 1'b0;
    endtask

    // Programs every channel and mirrors the values in the model
    task automatic configure(input int offset_kind, input bit random_shift, input int control);
        for (int ch = 0; ch < `CALIB_CHANNELS; ch++) begin
            offset_model[ch] = random_data(offset_kind);
            shift_model[ch] = random_shift ? ($random(seed) & ((1 << `CALIB_SHIFT_WIDTH) - 1)) : 0;
            signed_model[ch] = control[config_pkg::OUTPUT_SIGNED_LSB + ch];
            write_register(config_pkg::OFFSET_BASE + ch, offset_model[ch]);
            write_register(config_pkg::SHIFT_BASE + ch, shift_model[ch]);
        end
        shift_enable_model = control[config_pkg::SHIFT_ENABLE_BIT];
        write_register(config_pkg::CONTROL_ADDRESS, control);
    endtask

    // Sends one test's samples, each held until accepted, and records the expected outputs
    task automatic run_traffic(input int kind, input bit throttle);
        stream_pkg::raw_sample_t sample;
        int sent;
        bit pending;
        sample = '0;
        sent = 0;
        pending = 1'b0;
        while (sent < SAMPLES_PER_TEST) begin
            out_ready = !throttle || ($random(seed) & 1);
            if (!pending && (!throttle || ($random(seed) & 3) != 0)) begin
                sample.data = random_data(kind);
                sample.dest = $random(seed) & (`CALIB_CHANNELS - 1);
                pending = 1'b1;
            end
            in_valid = pending;
            in_sample = sample;
            // in_ready comes from a flop, so its value now holds through the next edge
            if (pending && in_ready) begin
                output_checker.add_expected(expected_sample(sample.data, sample.dest));
                sent++;
                pending = 1'b0;
            end
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
    endtask

    // Runs one test, lets the pipeline empty and prints the outcome
    task automatic run_test(input string name, input int kind, input bit throttle);
        int errors_before;
        int cycles;
        errors_before = output_checker.error_count + tb_errors;
        run_traffic(kind, throttle);
        cycles = 0;
        while (output_checker.pending_count() != 0 && cycles < 100) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (output_checker.pending_count() != 0) begin
            $display("Error: %0d samples of test %s never came out of the DUT",
                     output_checker.pending_count(), name);
            tb_errors++;
        end
        $display("Test %s done: %0d samples, %0d errors", name, SAMPLES_PER_TEST,
                 output_checker.error_count + tb_errors - errors_before);
    endtask

    initial begin
        seed = 32'ha0fe_4875;
        tb_errors = 0;
        clock = 1'b0;
        reset = 1'b0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_data = '0;
        in_valid = 1'b0;
        in_sample = '0;
        out_ready = 1'b1;
        // Model starts from the cleared register state
        for (int ch = 0; ch < `CALIB_CHANNELS; ch++) begin
            offset_model[ch] = 0;
            shift_model[ch] = 0;
            signed_model[ch] = 1'b0;
        end
        shift_enable_model = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;

        // Cleared registers pass non-negative samples straight through
        run_test("reset_defaults", NON_NEGATIVE, 1'b0);
        // All channels signed and offsets small, so nothing clamps
        configure(SMALL, 1'b0, 'h1e);
        run_test("offset_only", SMALL, 1'b0);
        // Channels 0 and 1 signed, channels 2 and 3 unsigned
        configure(LARGE, 1'b0, 'h06);
        run_test("saturation", LARGE, 1'b0);
        configure(SMALL, 1'b1, 'h1f);
        run_test("shift", FULL, 1'b0);
        run_test("back_pressure", FULL, 1'b1);
        // Shift on, channels 1 and 3 signed, channels 0 and 2 unsigned
        configure(FULL, 1'b1, 'h15);
        run_test("mixed_channels", FULL, 1'b0);

        repeat (10) @(posedge clock);
        if (output_checker.pending_count() != 0) begin
            $display("Error: %0d expected samples were still waiting at the end of the run",
                     output_checker.pending_count());
            tb_errors++;
        end
        $display("Done: %0d tests, %0d samples matched, %0d errors", TEST_COUNT,
                 output_checker.match_count, output_checker.error_count + tb_errors);
        if (output_checker.error_count + tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
